//--- common/zx_mem_params.svh
`ifndef ZX_MEM_PARAMS_SVH
`define ZX_MEM_PARAMS_SVH

// Bus widths
`define ZX_CPU_AW      16
`define ZX_PHYS_AW     25
`define ZX_DATA_W      8

// 16K page geometry in the flat RAM
`define ZX_PAGE_OFS_W  14
`define ZX_ROM_PAGE_W  4
`define ZX_RAM_PAGE_W  6

// ROM images live at 101 + page + offset
`define ZX_ROM_BASE    3'b101

// Paging port decodes as mask and match pairs
`define ZX_P7FFD_MASK  16'h8002
`define ZX_P7FFD_MATCH 16'h0000
`define ZX_P1FFD_MASK  16'hF002
`define ZX_P1FFD_MATCH 16'h1000
`define ZX_PEFF7_MASK  16'hF008
`define ZX_PEFF7_MATCH 16'hE000

`endif

//--- common/zx_mem_pkg.sv
package zx_mem_pkg;

	// Machine selected at reset
	typedef enum logic [2:0] {
		ZX128 = 3'd0,
		P1024 = 3'd1,
		PROFI = 3'd2,   // Behaves as 128K here
		ZX48  = 3'd3,
		PLUS3 = 3'd4
	} machine_t;

	// Port 7FFD, two readings of the same byte
	typedef union packed {
		struct packed {
			logic [1:0] unused;
			logic       lock;     // Paging lock until reset
			logic       rom;
			logic       screen;
			logic [2:0] bank;
		} std;
		struct packed {
			logic [1:0] ext_hi;   // Extended page bits on Pentagon 1024
			logic       ext_lo;
			logic       rom;
			logic       screen;
			logic [2:0] bank;
		} p1024;
	} page_7ffd_u;

	// Port 1FFD on the +3
	typedef struct packed {
		logic [3:0] upper;
		logic       motor;
		logic [1:0] mode;       // Bit 1 doubles as ROM page high bit
		logic       special;    // All-RAM layouts
	} page_1ffd_t;

	// Pending RAM operation
	typedef enum logic [1:0] {
		NONE  = 2'd0,
		READ  = 2'd1,
		WRITE = 2'd2
	} ram_op_t;

endpackage

//--- common/port_wr_if.sv
`timescale 1ns/1ps
`include "zx_mem_params.svh"

// Decoded paging port writes, one strobe per port
interface port_wr_if;
	logic                  wr_7ffd;
	logic                  wr_1ffd;
	logic                  wr_eff7;
	logic [`ZX_DATA_W-1:0] data;    // Byte written by the CPU

	modport source (
		output wr_7ffd,
		output wr_1ffd,
		output wr_eff7,
		output data
	);

	modport sink (
		input wr_7ffd,
		input wr_1ffd,
		input wr_eff7,
		input data
	);
endinterface

//--- common/paging_if.sv
`timescale 1ns/1ps

// Page register state seen by the address mapper
interface paging_if;
	zx_mem_pkg::page_7ffd_u p7ffd;
	zx_mem_pkg::page_1ffd_t p1ffd;
	logic [7:0]             eff7;
	logic [2:0]             page_128k;   // High bits of the slot 3 page
	zx_mem_pkg::machine_t   machine;

	modport source (
		output p7ffd,
		output p1ffd,
		output eff7,
		output page_128k,
		output machine
	);

	modport sink (
		input p7ffd,
		input p1ffd,
		input eff7,
		input page_128k,
		input machine
	);
endinterface

//--- paging/port_decode.sv
`timescale 1ns/1ps
`include "zx_mem_params.svh"

module port_decode (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic [`ZX_CPU_AW-1:0] cpu_addr,
	input  logic [`ZX_DATA_W-1:0] cpu_dout,
	input  logic                  iorq_n,
	input  logic                  wr_n,
	input  logic                  m1_n,
	input  logic                  is_plus3,
	port_wr_if.source             wr
);

	logic io_wr;
	logic io_wr_q;
	logic io_wr_edge;
	logic hit_7ffd;
	logic hit_1ffd;
	logic hit_eff7;

	// I/O write outside of interrupt acknowledge
	assign io_wr      = ~iorq_n & ~wr_n & m1_n;
	assign io_wr_edge = io_wr & ~io_wr_q;

	// Partial decodes, as on the real machines
	assign hit_7ffd = ((cpu_addr & `ZX_P7FFD_MASK) == `ZX_P7FFD_MATCH) &
	                  (cpu_addr[14] | ~is_plus3);
	assign hit_1ffd = ((cpu_addr & `ZX_P1FFD_MASK) == `ZX_P1FFD_MATCH) & is_plus3;
	assign hit_eff7 = (cpu_addr & `ZX_PEFF7_MASK) == `ZX_PEFF7_MATCH;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q    <= 1'b0;
			wr.wr_7ffd <= 1'b0;
			wr.wr_1ffd <= 1'b0;
			wr.wr_eff7 <= 1'b0;
		end else begin
			io_wr_q    <= io_wr;
			wr.wr_7ffd <= io_wr_edge & hit_7ffd;   // Single cycle each
			wr.wr_1ffd <= io_wr_edge & hit_1ffd;
			wr.wr_eff7 <= io_wr_edge & hit_eff7;
		end
	end

	// Data byte travels with the strobe
	always_ff @(posedge clk_sys) begin
		if (io_wr_edge) begin
			wr.data <= cpu_dout;
		end
	end

endmodule

//--- paging/page_regs.sv
`timescale 1ns/1ps

module page_regs (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  zx_mem_pkg::machine_t mode,
	port_wr_if.sink              wr,
	paging_if.source             pg,
	output logic                 is_plus3
);

	zx_mem_pkg::machine_t   machine;
	zx_mem_pkg::page_7ffd_u p7ffd;
	zx_mem_pkg::page_1ffd_t p1ffd;
	logic [7:0]             eff7;
	logic [2:0]             page_128k;

	zx_mem_pkg::page_7ffd_u din;
	logic                   is_zx48;
	logic                   is_p1024;
	logic                   page_disable;

	// ====================================================================
	// Machine flags
	// ====================================================================

	assign is_zx48  = machine == zx_mem_pkg::ZX48;
	assign is_p1024 = machine == zx_mem_pkg::P1024;
	assign is_plus3 = machine == zx_mem_pkg::PLUS3;

	assign din = wr.data;

	// Lock only counts on the 1024 once EFF7 bit 2 is set
	assign page_disable = is_zx48 |
	                      (~is_p1024 & p7ffd.std.lock) |
	                      (is_p1024 & eff7[2] & p7ffd.std.lock);

	// ====================================================================
	// Registers
	// ====================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			// Profi runs as a plain 128K
			machine   <= (mode == zx_mem_pkg::PROFI) ? zx_mem_pkg::ZX128 : mode;
			p7ffd     <= '0;
			p1ffd     <= '0;
			eff7      <= '0;
			page_128k <= '0;
		end else begin
			if (wr.wr_7ffd && !page_disable) begin
				p7ffd <= din;
				if (is_p1024 && !eff7[2]) begin
					page_128k <= {din.p1024.ext_lo, din.p1024.ext_hi};   // 1024K extension
				end
			end
			if (wr.wr_1ffd && !page_disable) begin
				p1ffd <= zx_mem_pkg::page_1ffd_t'(wr.data);
			end
			if (wr.wr_eff7 && is_p1024) begin
				eff7 <= wr.data;   // Lock does not apply here
			end
		end
	end

	// State out to the mapper
	assign pg.machine   = machine;
	assign pg.p7ffd     = p7ffd;
	assign pg.p1ffd     = p1ffd;
	assign pg.eff7      = eff7;
	assign pg.page_128k = page_128k;

endmodule

//--- paging/addr_map.sv
`timescale 1ns/1ps
`include "zx_mem_params.svh"

module addr_map (
	paging_if.sink                 pg,
	input  logic [`ZX_CPU_AW-1:0]  cpu_addr,
	output logic [`ZX_PHYS_AW-1:0] phys_addr,
	output logic                   write_ok
);

	localparam int ROM_PAD_W = `ZX_PHYS_AW - 3 - `ZX_ROM_PAGE_W - `ZX_PAGE_OFS_W;
	localparam int RAM_PAD_W = `ZX_PHYS_AW - `ZX_RAM_PAGE_W - `ZX_PAGE_OFS_W;

	logic [1:0]                  slot;
	logic [`ZX_PAGE_OFS_W-1:0]   ofs;
	logic                        special;
	logic [1:0]                  sp_mode;
	logic                        zx48;
	logic [`ZX_ROM_PAGE_W-1:0]   rom_page;
	logic [`ZX_RAM_PAGE_W-1:0]   ram_page;

	assign slot    = cpu_addr[`ZX_CPU_AW-1 -: 2];
	assign ofs     = cpu_addr[`ZX_PAGE_OFS_W-1:0];
	assign special = pg.p1ffd.special;
	assign sp_mode = pg.p1ffd.mode;
	assign zx48    = pg.machine == zx_mem_pkg::ZX48;

	// ROM image selection
	always_comb begin
		if (pg.machine == zx_mem_pkg::PLUS3) begin
			rom_page = {2'b10, pg.p1ffd.mode[1], pg.p7ffd.std.rom};
		end else begin
			rom_page = {zx48, 2'b11, zx48 | pg.p7ffd.std.rom};
		end
	end

	// RAM page per slot
	always_comb begin
		ram_page = '0;
		if (special) begin
			// +3 all-RAM layouts 0123, 4567, 4563, 4763
			case (slot)
				2'd0: ram_page[2:0] = {|sp_mode, 2'b00};
				2'd1: ram_page[2:0] = {|sp_mode, &sp_mode, 1'b1};
				2'd2: ram_page[2:0] = {|sp_mode, 2'b10};
				default: ram_page[2:0] = {~sp_mode[1] & sp_mode[0], 2'b11};
			endcase
		end else begin
			case (slot)
				2'd1: ram_page = 6'd5;
				2'd2: ram_page = 6'd2;
				default: ram_page = {pg.page_128k, pg.p7ffd.std.bank};   // Slot 3 paged bank
			endcase
		end
	end

	always_comb begin
		if (!special && slot == 2'd0) begin
			phys_addr = {{ROM_PAD_W{1'b0}}, `ZX_ROM_BASE, rom_page, ofs};
		end else begin
			phys_addr = {{RAM_PAD_W{1'b0}}, ram_page, ofs};
		end
	end

	assign write_ok = special | (slot != 2'd0);   // ROM is read only

endmodule

//--- design/ram_access.sv
`timescale 1ns/1ps
`include "zx_mem_params.svh"

module ram_access (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   mreq_n,
	input  logic                   rd_n,
	input  logic                   wr_n,
	input  logic [`ZX_DATA_W-1:0]  cpu_dout,
	output logic [`ZX_DATA_W-1:0]  cpu_din,
	output logic                   cpu_wait,
	input  logic [`ZX_PHYS_AW-1:0] phys_addr,
	input  logic                   write_ok,
	output logic [`ZX_PHYS_AW-1:0] ram_addr,
	output logic [`ZX_DATA_W-1:0]  ram_din,
	output logic                   ram_we,
	output logic                   ram_req,
	input  logic                   ram_ack,
	input  logic [`ZX_DATA_W-1:0]  ram_dout
);

	typedef enum logic [1:0] {
		st_idle,
		st_request,
		st_release,
		st_done
	} state_t;

	state_t                state;
	zx_mem_pkg::ram_op_t   op;
	logic [`ZX_DATA_W-1:0] rd_data;
	logic                  cpu_access;

	assign cpu_access = ~mreq_n & (~rd_n | ~wr_n);

	// ====================================================================
	// Four-phase handshake FSM
	// ====================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state    <= st_idle;
			op       <= zx_mem_pkg::NONE;
			ram_req  <= 1'b0;
			cpu_wait <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					op <= zx_mem_pkg::NONE;
					if (cpu_access) begin
						if (!wr_n && !write_ok) begin
							state <= st_done;   // ROM write, dropped silently
						end else begin
							op       <= wr_n ? zx_mem_pkg::READ : zx_mem_pkg::WRITE;
							ram_req  <= 1'b1;
							cpu_wait <= 1'b1;
							state    <= st_request;
						end
					end
				end
				st_request: begin
					if (ram_ack) begin
						ram_req <= 1'b0;
						state   <= st_release;
					end
				end
				st_release: begin
					if (!ram_ack) begin
						cpu_wait <= 1'b0;   // RAM is free again
						state    <= st_done;
					end
				end
				default: begin
					if (mreq_n) begin
						state <= st_idle;   // Wait for end of CPU cycle
					end
				end
			endcase
		end
	end

	// Address and data held for the whole transaction
	always_ff @(posedge clk_sys) begin
		if (state == st_idle && cpu_access) begin
			ram_addr <= phys_addr;
			ram_din  <= cpu_dout;
		end
		if (state == st_request && ram_ack) begin
			rd_data <= ram_dout;
		end
	end

	assign ram_we  = op == zx_mem_pkg::WRITE;
	assign cpu_din = (state == st_done && op == zx_mem_pkg::READ && !mreq_n) ? rd_data : 8'hFF;

endmodule

//--- design/zx_mem_top.sv
`timescale 1ns/1ps
`include "zx_mem_params.svh"

module zx_mem_top (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic [2:0]             mode,
	input  logic [`ZX_CPU_AW-1:0]  cpu_addr,
	input  logic [`ZX_DATA_W-1:0]  cpu_dout,
	output logic [`ZX_DATA_W-1:0]  cpu_din,
	input  logic                   mreq_n,
	input  logic                   iorq_n,
	input  logic                   rd_n,
	input  logic                   wr_n,
	input  logic                   m1_n,
	output logic                   cpu_wait,
	output logic [`ZX_PHYS_AW-1:0] ram_addr,
	output logic [`ZX_DATA_W-1:0]  ram_din,
	output logic                   ram_we,
	output logic                   ram_req,
	input  logic                   ram_ack,
	input  logic [`ZX_DATA_W-1:0]  ram_dout
);

	logic                   is_plus3;
	logic [`ZX_PHYS_AW-1:0] phys_addr;
	logic                   write_ok;

	port_wr_if wr_bus ();
	paging_if  pg_bus ();

	// ====================================================================
	// Paging ports and registers
	// ====================================================================

	port_decode port_decode_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu_addr (cpu_addr),
		.cpu_dout (cpu_dout),
		.iorq_n   (iorq_n),
		.wr_n     (wr_n),
		.m1_n     (m1_n),
		.is_plus3 (is_plus3),
		.wr       (wr_bus.source)
	);

	page_regs page_regs_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.mode     (zx_mem_pkg::machine_t'(mode)),
		.wr       (wr_bus.sink),
		.pg       (pg_bus.source),
		.is_plus3 (is_plus3)
	);

	// ====================================================================
	// Address translation and RAM access
	// ====================================================================

	addr_map addr_map_i (
		.pg        (pg_bus.sink),
		.cpu_addr  (cpu_addr),
		.phys_addr (phys_addr),
		.write_ok  (write_ok)
	);

	ram_access ram_access_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.mreq_n    (mreq_n),
		.rd_n      (rd_n),
		.wr_n      (wr_n),
		.cpu_dout  (cpu_dout),
		.cpu_din   (cpu_din),
		.cpu_wait  (cpu_wait),
		.phys_addr (phys_addr),
		.write_ok  (write_ok),
		.ram_addr  (ram_addr),
		.ram_din   (ram_din),
		.ram_we    (ram_we),
		.ram_req   (ram_req),
		.ram_ack   (ram_ack),
		.ram_dout  (ram_dout)
	);

endmodule

//--- testbench/tb_zx_mem_cases.svh
// Each row gives op, mode, cpu_addr, data, expected physical address and expected read byte
// FILL as read byte means the RAM model's fill pattern at the expected address

task automatic build_table();
	// 128K ROM select and fixed banks
	add_row(OP_RST, zx_mem_pkg::ZX128, 16'h0000, 8'h00, 25'h0, FILL);
	add_row(OP_RD,  zx_mem_pkg::ZX128, 16'h0100, 8'h00, rom_pa(4'd6, 14'h0100), FILL);
	add_row(OP_RD,  zx_mem_pkg::ZX128, 16'h4010, 8'h00, ram_pa(6'd5, 14'h0010), FILL);
	add_row(OP_RD,  zx_mem_pkg::ZX128, 16'h8020, 8'h00, ram_pa(6'd2, 14'h0020), FILL);
	add_row(OP_RD,  zx_mem_pkg::ZX128, 16'hC000, 8'h00, ram_pa(6'd0, 14'h0000), FILL);
	add_row(OP_IO,  zx_mem_pkg::ZX128, 16'h7FFD, 8'h10, 25'h0, FILL);
	add_row(OP_RD,  zx_mem_pkg::ZX128, 16'h0100, 8'h00, rom_pa(4'd7, 14'h0100), FILL);
	add_row(OP_RD,  zx_mem_pkg::ZX128, 16'h4010, 8'h00, ram_pa(6'd5, 14'h0010), FILL);
	add_row(OP_RD,  zx_mem_pkg::ZX128, 16'h8020, 8'h00, ram_pa(6'd2, 14'h0020), FILL);
	// Bank 6 in slot 3 and then the lock
	add_row(OP_IO,  zx_mem_pkg::ZX128, 16'h7FFD, 8'h06, 25'h0, FILL);
	add_row(OP_WR,  zx_mem_pkg::ZX128, 16'hC123, 8'hA5, ram_pa(6'd6, 14'h0123), 9'h000);
	add_row(OP_RD,  zx_mem_pkg::ZX128, 16'hC123, 8'h00, ram_pa(6'd6, 14'h0123), 9'h0A5);
	add_row(OP_RD,  zx_mem_pkg::ZX128, 16'h0000, 8'h00, rom_pa(4'd6, 14'h0000), FILL);
	add_row(OP_IO,  zx_mem_pkg::ZX128, 16'h7FFD, 8'h26, 25'h0, FILL);
	add_row(OP_IO,  zx_mem_pkg::ZX128, 16'h7FFD, 8'h03, 25'h0, FILL);   // Locked out
	add_row(OP_RD,  zx_mem_pkg::ZX128, 16'hC123, 8'h00, ram_pa(6'd6, 14'h0123), 9'h0A5);
	// ROM write protection
	add_row(OP_RST,    zx_mem_pkg::ZX128, 16'h0000, 8'h00, 25'h0, FILL);
	add_row(OP_RD,     zx_mem_pkg::ZX128, 16'h1234, 8'h00, rom_pa(4'd6, 14'h1234), FILL);
	add_row(OP_WR_ROM, zx_mem_pkg::ZX128, 16'h1234, 8'h5A, rom_pa(4'd6, 14'h1234), 9'h000);
	add_row(OP_RD,     zx_mem_pkg::ZX128, 16'h1234, 8'h00, rom_pa(4'd6, 14'h1234), FILL);
	// +3 special layout and ROM select
	add_row(OP_RST, zx_mem_pkg::PLUS3, 16'h0000, 8'h00, 25'h0, FILL);
	add_row(OP_RD,  zx_mem_pkg::PLUS3, 16'h0200, 8'h00, rom_pa(4'd8, 14'h0200), FILL);
	add_row(OP_IO,  zx_mem_pkg::PLUS3, 16'h1FFD, 8'h01, 25'h0, FILL);
	add_row(OP_WR,  zx_mem_pkg::PLUS3, 16'h0200, 8'h3C, ram_pa(6'd0, 14'h0200), 9'h000);
	add_row(OP_RD,  zx_mem_pkg::PLUS3, 16'h0200, 8'h00, ram_pa(6'd0, 14'h0200), 9'h03C);
	add_row(OP_RD,  zx_mem_pkg::PLUS3, 16'hC000, 8'h00, ram_pa(6'd3, 14'h0000), FILL);
	add_row(OP_IO,  zx_mem_pkg::PLUS3, 16'h1FFD, 8'h04, 25'h0, FILL);
	add_row(OP_RD,  zx_mem_pkg::PLUS3, 16'h0200, 8'h00, rom_pa(4'd10, 14'h0200), FILL);
	add_row(OP_IO,  zx_mem_pkg::PLUS3, 16'h7FFD, 8'h10, 25'h0, FILL);
	add_row(OP_RD,  zx_mem_pkg::PLUS3, 16'h0200, 8'h00, rom_pa(4'd11, 14'h0200), FILL);
	// Pentagon 1024 extended pages with the lock gated by EFF7 bit 2
	add_row(OP_RST, zx_mem_pkg::P1024, 16'h0000, 8'h00, 25'h0, FILL);
	add_row(OP_IO,  zx_mem_pkg::P1024, 16'h7FFD, 8'hE4, 25'h0, FILL);
	add_row(OP_RD,  zx_mem_pkg::P1024, 16'hC040, 8'h00, ram_pa(6'd60, 14'h0040), FILL);
	add_row(OP_IO,  zx_mem_pkg::P1024, 16'h7FFD, 8'h41, 25'h0, FILL);
	add_row(OP_RD,  zx_mem_pkg::P1024, 16'hC040, 8'h00, ram_pa(6'd9, 14'h0040), FILL);
	add_row(OP_IO,  zx_mem_pkg::P1024, 16'hEFF7, 8'h04, 25'h0, FILL);
	add_row(OP_IO,  zx_mem_pkg::P1024, 16'h7FFD, 8'h25, 25'h0, FILL);
	add_row(OP_RD,  zx_mem_pkg::P1024, 16'hC040, 8'h00, ram_pa(6'd13, 14'h0040), FILL);
	add_row(OP_IO,  zx_mem_pkg::P1024, 16'h7FFD, 8'h03, 25'h0, FILL);
	add_row(OP_RD,  zx_mem_pkg::P1024, 16'hC040, 8'h00, ram_pa(6'd13, 14'h0040), FILL);
	// 48K ignores paging
	add_row(OP_RST, zx_mem_pkg::ZX48, 16'h0000, 8'h00, 25'h0, FILL);
	add_row(OP_RD,  zx_mem_pkg::ZX48, 16'h0000, 8'h00, rom_pa(4'd15, 14'h0000), FILL);
	add_row(OP_IO,  zx_mem_pkg::ZX48, 16'h7FFD, 8'h07, 25'h0, FILL);
	add_row(OP_RD,  zx_mem_pkg::ZX48, 16'hC000, 8'h00, ram_pa(6'd0, 14'h0000), FILL);
	add_row(OP_RD,  zx_mem_pkg::ZX48, 16'h3FFF, 8'h00, rom_pa(4'd15, 14'h3FFF), FILL);
	// Profi mode runs as 128K
	add_row(OP_RST, zx_mem_pkg::PROFI, 16'h0000, 8'h00, 25'h0, FILL);
	add_row(OP_RD,  zx_mem_pkg::PROFI, 16'h0000, 8'h00, rom_pa(4'd6, 14'h0000), FILL);
	add_row(OP_IO,  zx_mem_pkg::PROFI, 16'h7FFD, 8'h10, 25'h0, FILL);
	add_row(OP_RD,  zx_mem_pkg::PROFI, 16'h0000, 8'h00, rom_pa(4'd7, 14'h0000), FILL);
endtask

//--- testbench/tb_zx_mem.sv
`timescale 1ns/1ps
`include "zx_mem_params.svh"

module tb_zx_mem;

	localparam int MAX_ROWS   = 64;
	localparam int ROW_CYCLES = 200;   // Watchdog budget per table row

	// Row operations
	localparam logic [2:0] OP_RST    = 3'd0;   // Reset into the row's mode
	localparam logic [2:0] OP_IO     = 3'd1;
	localparam logic [2:0] OP_WR     = 3'd2;
	localparam logic [2:0] OP_RD     = 3'd3;
	localparam logic [2:0] OP_WR_ROM = 3'd4;   // Write that must never reach the RAM

	localparam logic [8:0] FILL = 9'h100;   // Expect the RAM fill byte

	logic                   clk_sys;
	logic                   reset;
	logic [2:0]             mode;
	logic [`ZX_CPU_AW-1:0]  cpu_addr;
	logic [`ZX_DATA_W-1:0]  cpu_dout;
	logic [`ZX_DATA_W-1:0]  cpu_din;
	logic                   mreq_n;
	logic                   iorq_n;
	logic                   rd_n;
	logic                   wr_n;
	logic                   m1_n;
	logic                   cpu_wait;
	logic [`ZX_PHYS_AW-1:0] ram_addr;
	logic [`ZX_DATA_W-1:0]  ram_din;
	logic                   ram_we;
	logic                   ram_req;
	logic                   ram_ack;
	logic [`ZX_DATA_W-1:0]  ram_dout;

	// RAM model state
	integer                 seed = 32'hc6e79038;
	logic [7:0]             mem [logic [`ZX_PHYS_AW-1:0]];
	logic [`ZX_PHYS_AW-1:0] last_addr;
	logic                   req_seen;
	logic                   ack_busy;
	int                     ack_delay;

	// Stimulus table
	logic [2:0]             row_op   [MAX_ROWS];
	logic [2:0]             row_mode [MAX_ROWS];
	logic [`ZX_CPU_AW-1:0]  row_addr [MAX_ROWS];
	logic [`ZX_DATA_W-1:0]  row_data [MAX_ROWS];
	logic [`ZX_PHYS_AW-1:0] row_pa   [MAX_ROWS];
	logic [8:0]             row_rd   [MAX_ROWS];
	int                     n_rows = 0;
	logic                   table_ready = 1'b0;

	initial clk_sys = 1'b0;
	always #5 clk_sys = ~clk_sys;

	zx_mem_top dut_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.mode     (mode),
		.cpu_addr (cpu_addr),
		.cpu_dout (cpu_dout),
		.cpu_din  (cpu_din),
		.mreq_n   (mreq_n),
		.iorq_n   (iorq_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.m1_n     (m1_n),
		.cpu_wait (cpu_wait),
		.ram_addr (ram_addr),
		.ram_din  (ram_din),
		.ram_we   (ram_we),
		.ram_req  (ram_req),
		.ram_ack  (ram_ack),
		.ram_dout (ram_dout)
	);

	// ====================================================================
	// Address helpers and table building
	// ====================================================================

	// Unwritten RAM returns a byte made from the whole address
	function automatic logic [7:0] fill_byte(input logic [`ZX_PHYS_AW-1:0] a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'd0, a[24]} ^ 8'h5A;
	endfunction

	function automatic logic [`ZX_PHYS_AW-1:0] rom_pa(input logic [3:0] page,
			input logic [13:0] ofs);
		return {4'd0, `ZX_ROM_BASE, page, ofs};
	endfunction

	function automatic logic [`ZX_PHYS_AW-1:0] ram_pa(input logic [5:0] page,
			input logic [13:0] ofs);
		return {5'd0, page, ofs};
	endfunction

	task automatic add_row(input logic [2:0] op, input logic [2:0] m,
			input logic [15:0] addr, input logic [7:0] data,
			input logic [`ZX_PHYS_AW-1:0] pa, input logic [8:0] rd);
		row_op[n_rows]   = op;
		row_mode[n_rows] = m;
		row_addr[n_rows] = addr;
		row_data[n_rows] = data;
		row_pa[n_rows]   = pa;
		row_rd[n_rows]   = rd;
		n_rows++;
	endtask

	`include "tb_zx_mem_cases.svh"

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// ====================================================================
	// RAM model, four-phase req/ack with random ack delay
	// ====================================================================

	always @(negedge clk_sys) begin
		if (reset) begin
			ram_ack  = 1'b0;
			ack_busy = 1'b0;
		end else if (ram_req && !ram_ack) begin
			if (!ack_busy) begin
				ack_busy  = 1'b1;
				req_seen  = 1'b1;
				last_addr = ram_addr;
				ack_delay = {$random(seed)} % 6;   // 0 to 5 cycles
			end
			if (ack_delay == 0) begin
				if (ram_we) begin
					mem[ram_addr] = ram_din;
				end
				ram_dout = mem.exists(ram_addr) ? mem[ram_addr] : fill_byte(ram_addr);
				ram_ack  = 1'b1;
			end else begin
				ack_delay = ack_delay - 1;
			end
		end else if (!ram_req && ram_ack) begin
			ram_ack  = 1'b0;
			ack_busy = 1'b0;
		end
	end

	// ====================================================================
	// CPU bus tasks, all called and returning on a falling edge
	// ====================================================================

	task automatic apply_reset(input logic [2:0] m);
		reset = 1'b1;
		mode  = m;   // Sampled while reset is high
		repeat (2) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
		check_value("ram_req after reset", ram_req, 0);
		check_value("cpu_wait after reset", cpu_wait, 0);
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		cpu_addr = addr;
		cpu_dout = data;
		iorq_n   = 1'b0;
		wr_n     = 1'b0;
		repeat (2) @(negedge clk_sys);   // Strobe, then register update
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic mem_access(input logic [2:0] op, input logic [15:0] addr,
			input logic [7:0] data, input logic [`ZX_PHYS_AW-1:0] exp_pa,
			input logic [8:0] exp_rd);
		logic [7:0] want;
		req_seen = 1'b0;
		cpu_addr = addr;
		cpu_dout = data;
		mreq_n   = 1'b0;
		if (op == OP_RD) begin
			rd_n = 1'b0;
		end else begin
			wr_n = 1'b0;
		end
		@(negedge clk_sys);
		if (op == OP_WR_ROM) begin
			@(negedge clk_sys);
			check_value("cpu_wait on ROM write", cpu_wait, 0);
			mreq_n = 1'b1;
			wr_n   = 1'b1;
			@(negedge clk_sys);
			check_value("ram_req on ROM write", req_seen, 0);
		end else begin
			check_value("cpu_wait raised", cpu_wait, 1);
			while (cpu_wait) @(negedge clk_sys);
			check_value("RAM address", last_addr, exp_pa);
			if (op == OP_RD) begin
				want = exp_rd[8] ? fill_byte(exp_pa) : exp_rd[7:0];
				check_value("read data", cpu_din, want);
			end else begin
				check_value("stored byte", mem[exp_pa], data);
			end
			mreq_n = 1'b1;
			rd_n   = 1'b1;
			wr_n   = 1'b1;
			@(negedge clk_sys);
			check_value("idle cpu_din", cpu_din, 8'hFF);
		end
	endtask

	initial begin
		reset     = 1'b1;
		mode      = 3'd0;
		cpu_addr  = '0;
		cpu_dout  = '0;
		mreq_n    = 1'b1;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		m1_n      = 1'b1;
		ram_ack   = 1'b0;
		ram_dout  = '0;
		req_seen  = 1'b0;
		ack_busy  = 1'b0;
		ack_delay = 0;
		last_addr = '0;
		build_table();
		table_ready = 1'b1;
		repeat (2) @(negedge clk_sys);
		reset = 1'b0;
		for (int i = 0; i < n_rows; i++) begin
			mode = row_mode[i];
			case (row_op[i])
				OP_RST: apply_reset(row_mode[i]);
				OP_IO: io_write(row_addr[i], row_data[i]);
				default: mem_access(row_op[i], row_addr[i], row_data[i], row_pa[i], row_rd[i]);
			endcase
		end
		$display("TESTS PASSED");
		$finish;
	end

	// Watchdog sized from the table length
	initial begin
		wait (table_ready);
		repeat (n_rows * ROW_CYCLES) @(posedge clk_sys);
		$display("Timeout: the table did not finish within %0d cycles", n_rows * ROW_CYCLES);
		$display("TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- verilog.f
+incdir+common
+incdir+testbench
common/zx_mem_pkg.sv
common/port_wr_if.sv
common/paging_if.sv
paging/port_decode.sv
paging/page_regs.sv
paging/addr_map.sv
design/ram_access.sv
design/zx_mem_top.sv
testbench/tb_zx_mem.sv

//--- Bender.yml
package:
  name: zx_mem

sources:
  - include_dirs:
      - common
    files:
      - common/zx_mem_pkg.sv
      - common/port_wr_if.sv
      - common/paging_if.sv
      - paging/port_decode.sv
      - paging/page_regs.sv
      - paging/addr_map.sv
      - design/ram_access.sv
      - design/zx_mem_top.sv
  - target: test
    include_dirs:
      - common
      - testbench
    files:
      - testbench/tb_zx_mem.sv
